// ==== mmio_top.f ====
design/mmio_bus_pkg.sv
design/mmio_map_pkg.sv
design/mmio_ctrl.sv
design/perf_counters.sv
design/button_fifo.sv
design/led_switch_port.sv
design/mmio_top.sv
verification/mmio_top_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f mmio_top.f \
    --top-module mmio_top_tb

sim_out=$(./obj_dir/Vmmio_top_tb 2>&1 || true)
echo "$sim_out"

if grep -q "Simulation finished: PASS" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== verification/mmio_top_tb.sv ====
`timescale 1ns/10ps

module mmio_top_tb;
    import mmio_bus_pkg::*;
    import mmio_map_pkg::*;

    localparam logic [ADDR_W-1:0] BASE        = 32'h8000_0000;
    localparam int                READY_LIMIT = 8;  // cycles allowed for pready
    localparam logic              RD          = 1'b0;
    localparam logic              WR          = 1'b1;

    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] offs;      // from BASE, may leave the block
        logic [DATA_W-1:0] wdata;
        logic [DATA_W-1:0] exp_data;
        logic              exp_err;
    } row_t;

    logic                clk;
    logic                rst;
    apb_req_t            apb_in;
    apb_rsp_t            apb_out;
    logic                instr_retire;
    logic [BUTTON_W-1:0] buttons;
    logic [SWITCH_W-1:0] switches;
    logic [LED_W-1:0]    leds;
    logic [PMOD_W-1:0]   pmod_leds;

    row_t                rows[$];
    logic [BUTTON_W-1:0] pressed[$];  // patterns in press order
    logic [31:0]         rng_state;
    int unsigned         clk_count = 0;

    mmio_top #(
        .MMIO_BASE (BASE),
        .FIFO_DEPTH(8)
    ) DUT (
        .clk         (clk),
        .rst         (rst),
        .apb_in      (apb_in),
        .instr_retire(instr_retire),
        .buttons     (buttons),
        .switches    (switches),
        .apb_out     (apb_out),
        .leds        (leds),
        .pmod_leds   (pmod_leds)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) clk_count <= clk_count + 1;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------

    // xorshift32 step on the shared seed
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[FAIL] %0t ns: %s = 0x%08h, expected 0x%08h",
                                $time, name, got, exp));
        end
    endtask

    // one APB transfer, setup then access until pready
    task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata, output logic err);
        int waited;
        @(negedge clk);
        apb_in.psel    = 1'b1;
        apb_in.penable = 1'b0;
        apb_in.pwrite  = write;
        apb_in.paddr   = addr;
        apb_in.pwdata  = wdata;
        @(negedge clk);
        apb_in.penable = 1'b1;  // access phase
        waited = 0;
        @(negedge clk);
        while (apb_out.pready !== 1'b1) begin
            if (waited == READY_LIMIT) begin
                abort_run($sformatf("pready did not rise within %0d cycles", READY_LIMIT));
            end
            waited++;
            @(negedge clk);
        end
        check_value("pready wait cycles", waited, 0);  // exactly one wait state
        rdata = apb_out.prdata;
        err   = apb_out.pslverr;
        @(negedge clk);  // held through the completing edge
        apb_in = '0;
    endtask

    task automatic add_row(input logic write, input logic [ADDR_W-1:0] offs,
                           input logic [DATA_W-1:0] wdata,
                           input logic [DATA_W-1:0] exp_data, input logic exp_err);
        row_t row;
        row.write    = write;
        row.offs     = offs;
        row.wdata    = wdata;
        row.exp_data = exp_data;
        row.exp_err  = exp_err;
        rows.push_back(row);
    endtask

    task automatic apply_rows();
        logic [DATA_W-1:0] rdata;
        logic              err;
        foreach (rows[i]) begin
            apb_transfer(rows[i].write, BASE + rows[i].offs, rows[i].wdata, rdata, err);
            check_value($sformatf("pslverr (row %0d)", i), 32'(err), 32'(rows[i].exp_err));
            check_value($sformatf("prdata (row %0d)", i), rdata, rows[i].exp_data);
        end
        rows.delete();
    endtask

    // press and release, pattern kept for the pops
    task automatic send_press();
        logic [31:0] r;
        r = next_random();
        if (r[BUTTON_W-1:0] == '0) begin
            r[0] = 1'b1;  // a press needs a nonzero vector
        end
        pressed.push_back(r[BUTTON_W-1:0]);
        @(negedge clk);
        buttons = r[BUTTON_W-1:0];
        repeat (6) @(negedge clk);
        buttons = '0;
        repeat (10) @(negedge clk);
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0]       led_word;
        logic [31:0]       led_fields;
        logic [31:0]       retire_n;
        logic [31:0]       sw_word;
        int unsigned       clear_mark;
        logic [DATA_W-1:0] rdata;
        logic              err;

        rst          = 1'b1;
        apb_in       = '0;
        instr_retire = 1'b0;
        buttons      = '0;
        switches     = '0;
        rng_state    = 32'h1334_500e;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // reset values, status reads empty
        add_row(RD, 32'(REG_INSTR), '0, '0, 1'b0);
        add_row(RD, 32'(REG_FIFO_STATUS), '0, 32'h1, 1'b0);
        add_row(RD, 32'(REG_FIFO_DATA), '0, '0, 1'b0);
        add_row(RD, 32'(REG_SWITCHES), '0, '0, 1'b0);
        add_row(RD, 32'(REG_LEDS), '0, '0, 1'b0);
        apply_rows();
        check_value("leds", 32'(leds), '0);
        check_value("pmod_leds", 32'(pmod_leds), '0);

        // LED write and readback
        led_word   = next_random();
        led_fields = {16'h0, led_word[15:8], 2'b00, led_word[5:0]};
        add_row(WR, 32'(REG_LEDS), led_word, '0, 1'b0);
        add_row(RD, 32'(REG_LEDS), '0, led_fields, 1'b0);
        apply_rows();
        check_value("leds", 32'(leds), 32'(led_word[5:0]));
        check_value("pmod_leds", 32'(pmod_leds), 32'(led_word[15:8]));

        // counters after a clear
        add_row(WR, 32'(REG_CNT_CLEAR), next_random(), '0, 1'b0);
        apply_rows();
        clear_mark = clk_count;
        retire_n   = (next_random() % 20) + 1;
        for (int i = 0; i < retire_n; i++) begin
            @(negedge clk);
            instr_retire = 1'b1;
            @(negedge clk);
            instr_retire = 1'b0;
        end
        add_row(RD, 32'(REG_INSTR), '0, retire_n, 1'b0);
        apply_rows();
        apb_transfer(RD, BASE + 32'(REG_CYCLE), '0, rdata, err);
        check_value("pslverr", 32'(err), '0);
        assert (rdata != '0 && rdata < (clk_count - clear_mark)) else begin
            abort_run($sformatf("[FAIL] %0t ns: REG_CYCLE = %0d, expected 1 to %0d",
                                $time, rdata, clk_count - clear_mark - 1));
        end

        // presses popped in order, then empty
        repeat (5) send_press();
        foreach (pressed[k]) add_row(RD, 32'(REG_FIFO_DATA), '0, 32'(pressed[k]), 1'b0);
        add_row(RD, 32'(REG_FIFO_STATUS), '0, 32'h1, 1'b0);
        add_row(RD, 32'(REG_FIFO_DATA), '0, '0, 1'b0);
        apply_rows();
        pressed.delete();

        // overflow drops the last two
        repeat (10) send_press();
        add_row(RD, 32'(REG_FIFO_STATUS), '0, 32'h2, 1'b0);
        for (int k = 0; k < 8; k++) begin
            add_row(RD, 32'(REG_FIFO_DATA), '0, 32'(pressed[k]), 1'b0);
        end
        add_row(RD, 32'(REG_FIFO_STATUS), '0, 32'h1, 1'b0);
        add_row(RD, 32'(REG_FIFO_DATA), '0, '0, 1'b0);
        apply_rows();

        // switches, then error responses without side effects
        sw_word = (next_random() % 3) + 1;
        @(negedge clk);
        switches = sw_word[SWITCH_W-1:0];
        repeat (3) @(negedge clk);
        add_row(RD, 32'(REG_CNT_CLEAR), '0, '0, 1'b1);
        add_row(WR, 32'(REG_SWITCHES), next_random(), '0, 1'b1);
        add_row(RD, 32'h3c, '0, '0, 1'b1);               // unmapped
        add_row(WR, 32'h3c, next_random(), '0, 1'b1);
        add_row(RD, 32'h110, '0, '0, 1'b1);              // outside the base
        add_row(WR, 32'h130, next_random(), '0, 1'b1);
        add_row(WR, 32'h118, next_random(), '0, 1'b1);
        add_row(RD, 32'(REG_SWITCHES), '0, sw_word, 1'b0);
        add_row(RD, 32'(REG_INSTR), '0, retire_n, 1'b0);
        add_row(RD, 32'(REG_LEDS), '0, led_fields, 1'b0);
        add_row(RD, 32'(REG_FIFO_STATUS), '0, 32'h1, 1'b0);
        apply_rows();
        check_value("leds", 32'(leds), 32'(led_word[5:0]));
        check_value("pmod_leds", 32'(pmod_leds), 32'(led_word[15:8]));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== design/mmio_top.sv ====
`timescale 1ns/10ps

module mmio_top #(
    parameter logic [mmio_bus_pkg::ADDR_W-1:0] MMIO_BASE  = 32'h8000_0000,
    parameter int                              FIFO_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  mmio_bus_pkg::apb_req_t            apb_in,
    input  logic                              instr_retire,
    input  logic [mmio_map_pkg::BUTTON_W-1:0] buttons,
    input  logic [mmio_map_pkg::SWITCH_W-1:0] switches,
    output mmio_bus_pkg::apb_rsp_t            apb_out,
    output logic [mmio_map_pkg::LED_W-1:0]    leds,
    output logic [mmio_map_pkg::PMOD_W-1:0]   pmod_leds
);
    import mmio_bus_pkg::*;
    import mmio_map_pkg::*;

    // datapath to controller
    logic [DATA_W-1:0]   cycle_count;
    logic [DATA_W-1:0]   instr_count;
    logic                fifo_empty;
    logic                fifo_full;
    logic [BUTTON_W-1:0] fifo_data;
    logic [SWITCH_W-1:0] switch_value;

    // controller strobes
    logic                cnt_clear;
    logic                fifo_pop;
    logic                led_we;
    logic [DATA_W-1:0]   led_wdata;

    mmio_ctrl #(
        .MMIO_BASE(MMIO_BASE)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .apb_in      (apb_in),
        .cycle_count (cycle_count),
        .instr_count (instr_count),
        .fifo_empty  (fifo_empty),
        .fifo_full   (fifo_full),
        .fifo_data   (fifo_data),
        .switch_value(switch_value),
        .led_value   (leds),       // readback of the pin registers
        .pmod_value  (pmod_leds),
        .apb_out     (apb_out),
        .cnt_clear   (cnt_clear),
        .fifo_pop    (fifo_pop),
        .led_we      (led_we),
        .led_wdata   (led_wdata)
    );

    perf_counters u_counters (
        .clk         (clk),
        .rst         (rst),
        .instr_retire(instr_retire),
        .cnt_clear   (cnt_clear),
        .cycle_count (cycle_count),
        .instr_count (instr_count)
    );

    button_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_buttons (
        .clk       (clk),
        .rst       (rst),
        .buttons   (buttons),
        .fifo_pop  (fifo_pop),
        .fifo_data (fifo_data),
        .fifo_empty(fifo_empty),
        .fifo_full (fifo_full)
    );

    led_switch_port u_gpio (
        .clk         (clk),
        .rst         (rst),
        .switches    (switches),
        .led_we      (led_we),
        .led_wdata   (led_wdata),
        .leds        (leds),
        .pmod_leds   (pmod_leds),
        .switch_value(switch_value)
    );

endmodule

// ==== design/led_switch_port.sv ====
`timescale 1ns/10ps

module led_switch_port (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mmio_map_pkg::SWITCH_W-1:0] switches,
    input  logic                              led_we,
    input  logic [mmio_bus_pkg::DATA_W-1:0]   led_wdata,
    output logic [mmio_map_pkg::LED_W-1:0]    leds,
    output logic [mmio_map_pkg::PMOD_W-1:0]   pmod_leds,
    output logic [mmio_map_pkg::SWITCH_W-1:0] switch_value
);
    import mmio_map_pkg::*;

    logic [SWITCH_W-1:0] sw_meta;

    // ------------------------------------------------------------------
    // LED write register
    // ------------------------------------------------------------------

    // one word carries both fields, bits 7:6 are ignored
    always_ff @(posedge clk) begin
        if (rst) begin
            leds      <= '0;
            pmod_leds <= '0;
        end else if (led_we) begin
            leds      <= led_wdata[LED_W-1:0];
            pmod_leds <= led_wdata[PMOD_LSB +: PMOD_W];
        end
    end

    // ------------------------------------------------------------------
    // switch synchronizer
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            sw_meta      <= '0;
            switch_value <= '0;
        end else begin
            sw_meta      <= switches;
            switch_value <= sw_meta;  // two flops behind the pins
        end
    end

endmodule

// ==== design/button_fifo.sv ====
`timescale 1ns/10ps

module button_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mmio_map_pkg::BUTTON_W-1:0] buttons,
    input  logic                              fifo_pop,
    output logic [mmio_map_pkg::BUTTON_W-1:0] fifo_data,
    output logic                              fifo_empty,
    output logic                              fifo_full
);
    import mmio_map_pkg::*;

    localparam int              PTR_W    = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0]  FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

    logic [BUTTON_W-1:0] btn_meta;
    logic [BUTTON_W-1:0] btn_sync;
    logic [BUTTON_W-1:0] btn_prev;
    logic                press;
    logic                push;

    logic [BUTTON_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;

    // ------------------------------------------------------------------
    // synchronizer and press detect
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_prev <= '0;
        end else begin
            btn_meta <= buttons;
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;  // edge register
        end
    end

    // none to some, holding a button queues only once
    assign press = (btn_prev == '0) && (btn_sync != '0);
    assign push  = press && !fifo_full;  // drop when full

    // ------------------------------------------------------------------
    // circular buffer
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= btn_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    assign fifo_data  = mem[rd_ptr];  // oldest entry
    assign fifo_empty = (count == '0);
    assign fifo_full  = (count == FULL_CNT);

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= FULL_CNT);

    // the controller is trusted to check empty before popping
    a_no_empty_pop: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |-> !fifo_empty);

endmodule

// ==== design/perf_counters.sv ====
`timescale 1ns/10ps

module perf_counters (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            instr_retire,
    input  logic                            cnt_clear,
    output logic [mmio_bus_pkg::DATA_W-1:0] cycle_count,
    output logic [mmio_bus_pkg::DATA_W-1:0] instr_count
);

    // ------------------------------------------------------------------
    // benchmark counters
    // ------------------------------------------------------------------

    // free running, wraps at 2^32
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // one tick per retire strobe from the core
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            instr_count <= '0;  // clear beats a retire in the same cycle
        end else if (instr_retire) begin
            instr_count <= instr_count + 1'b1;
        end
    end

endmodule

// ==== design/mmio_ctrl.sv ====
`timescale 1ns/10ps

module mmio_ctrl #(
    parameter logic [mmio_bus_pkg::ADDR_W-1:0] MMIO_BASE = 32'h8000_0000
) (
    input  logic                              clk,
    input  logic                              rst,
    input  mmio_bus_pkg::apb_req_t            apb_in,
    input  logic [mmio_bus_pkg::DATA_W-1:0]   cycle_count,
    input  logic [mmio_bus_pkg::DATA_W-1:0]   instr_count,
    input  logic                              fifo_empty,
    input  logic                              fifo_full,
    input  logic [mmio_map_pkg::BUTTON_W-1:0] fifo_data,
    input  logic [mmio_map_pkg::SWITCH_W-1:0] switch_value,
    input  logic [mmio_map_pkg::LED_W-1:0]    led_value,
    input  logic [mmio_map_pkg::PMOD_W-1:0]   pmod_value,
    output mmio_bus_pkg::apb_rsp_t            apb_out,
    output logic                              cnt_clear,
    output logic                              fifo_pop,
    output logic                              led_we,
    output logic [mmio_bus_pkg::DATA_W-1:0]   led_wdata
);
    import mmio_bus_pkg::*;
    import mmio_map_pkg::*;

    localparam int OFFS_W = $bits(mmio_reg_e);

    ctrl_state_e       state;
    mmio_reg_e         offset;
    logic              base_hit;
    logic              rd_ok;
    logic              wr_ok;
    logic              xfer_err;
    logic [DATA_W-1:0] rd_word;

    // captured in WAIT, used in RESPOND
    logic [DATA_W-1:0] prdata_q;
    logic [DATA_W-1:0] wdata_q;
    logic              err_q;
    logic              clear_q;
    logic              pop_q;
    logic              led_q;

    // ------------------------------------------------------------------
    // address decode and read mux
    // ------------------------------------------------------------------

    assign offset   = mmio_reg_e'(apb_in.paddr[OFFS_W-1:0]);
    assign base_hit = (apb_in.paddr[ADDR_W-1:OFFS_W] == MMIO_BASE[ADDR_W-1:OFFS_W]);

    always_comb begin
        rd_ok   = 1'b0;
        wr_ok   = 1'b0;
        rd_word = '0;
        case (offset)
            REG_CYCLE: begin
                rd_ok   = 1'b1;
                rd_word = cycle_count;
            end
            REG_INSTR: begin
                rd_ok   = 1'b1;
                rd_word = instr_count;
            end
            REG_CNT_CLEAR: wr_ok = 1'b1;  // write data ignored
            REG_FIFO_STATUS: begin
                rd_ok                   = 1'b1;
                rd_word[STAT_EMPTY_BIT] = fifo_empty;
                rd_word[STAT_FULL_BIT]  = fifo_full;
            end
            REG_FIFO_DATA: begin
                rd_ok = 1'b1;
                if (!fifo_empty) begin
                    rd_word[BUTTON_W-1:0] = fifo_data;  // empty reads as zero
                end
            end
            REG_SWITCHES: begin
                rd_ok                 = 1'b1;
                rd_word[SWITCH_W-1:0] = switch_value;
            end
            REG_LEDS: begin
                rd_ok                        = 1'b1;
                wr_ok                        = 1'b1;
                rd_word[LED_W-1:0]           = led_value;
                rd_word[PMOD_LSB +: PMOD_W]  = pmod_value;
            end
            default: ;  // unknown offset, neither direction allowed
        endcase
    end

    assign xfer_err = !base_hit || (apb_in.pwrite ? !wr_ok : !rd_ok);

    // ------------------------------------------------------------------
    // slave FSM
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            prdata_q <= '0;
            err_q    <= 1'b0;
            clear_q  <= 1'b0;
            pop_q    <= 1'b0;
            led_q    <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (apb_in.psel && !apb_in.penable) begin
                        state <= WAIT;  // setup phase seen
                    end
                end
                WAIT: begin
                    if (apb_in.psel && apb_in.penable) begin
                        state    <= RESPOND;
                        err_q    <= xfer_err;
                        prdata_q <= (xfer_err || apb_in.pwrite) ? '0 : rd_word;
                        clear_q  <= !xfer_err && apb_in.pwrite && (offset == REG_CNT_CLEAR);
                        led_q    <= !xfer_err && apb_in.pwrite && (offset == REG_LEDS);
                        // pop decided here so a late push cannot be lost
                        pop_q    <= !xfer_err && !apb_in.pwrite &&
                                    (offset == REG_FIFO_DATA) && !fifo_empty;
                    end else begin
                        state <= IDLE;  // master abandoned the transfer
                    end
                end
                RESPOND: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT) begin
            wdata_q <= apb_in.pwdata;
        end
    end

    // ------------------------------------------------------------------
    // response and side-effect strobes
    // ------------------------------------------------------------------

    assign apb_out.prdata  = prdata_q;
    assign apb_out.pready  = (state == RESPOND);
    assign apb_out.pslverr = (state == RESPOND) && err_q;

    assign cnt_clear = (state == RESPOND) && clear_q;
    assign fifo_pop  = (state == RESPOND) && pop_q;
    assign led_we    = (state == RESPOND) && led_q;
    assign led_wdata = wdata_q;

    // ready only ends a transfer the master has held through two access cycles
    a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_out.pready |-> apb_in.psel && apb_in.penable &&
                           $past(apb_in.psel && apb_in.penable));

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        $onehot0({cnt_clear, fifo_pop, led_we}));

endmodule

// ==== design/mmio_map_pkg.sv ====
package mmio_map_pkg;

    // ------------------------------------------------------------------
    // register map, byte offsets from the block base
    // ------------------------------------------------------------------

    typedef enum logic [7:0] {
        REG_CYCLE       = 8'h10,  // ro, cycle counter
        REG_INSTR       = 8'h14,  // ro, retired instructions
        REG_CNT_CLEAR   = 8'h18,  // wo, any write clears both counters
        REG_FIFO_STATUS = 8'h20,  // ro, bit 0 empty, bit 1 full
        REG_FIFO_DATA   = 8'h24,  // ro, read pops the oldest press
        REG_SWITCHES    = 8'h28,  // ro
        REG_LEDS        = 8'h30   // rw, leds 5:0, pmod leds 15:8
    } mmio_reg_e;

    // APB slave sequencing
    typedef enum logic [1:0] {
        IDLE,
        WAIT,     // access phase, decode and capture
        RESPOND   // pready high
    } ctrl_state_e;

    // ------------------------------------------------------------------
    // board I/O field widths
    // ------------------------------------------------------------------

    localparam int BUTTON_W = 4;
    localparam int SWITCH_W = 2;
    localparam int LED_W    = 6;
    localparam int PMOD_W   = 8;

    // bit positions inside the status and LED words
    localparam int STAT_EMPTY_BIT = 0;
    localparam int STAT_FULL_BIT  = 1;
    localparam int PMOD_LSB       = 8;

endpackage

// ==== design/mmio_bus_pkg.sv ====
package mmio_bus_pkg;

    // ------------------------------------------------------------------
    // APB widths
    // ------------------------------------------------------------------

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // ------------------------------------------------------------------
    // APB request, master to slave (67 bits)
    // ------------------------------------------------------------------

    typedef struct packed {
        logic              psel;     // slave selected
        logic              penable;  // high in the access phase
        logic              pwrite;   // 1 = write, 0 = read
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    // ------------------------------------------------------------------
    // APB response, slave to master (34 bits)
    // ------------------------------------------------------------------

    // pslverr only means something while pready is high
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

endpackage
